// ==== Bender.yml ====
package:
  name: shader_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/core_pkg.sv
  - hw/fetch_unit.sv
  - hw/inst_queue.sv
  - hw/rv_decoder.sv
  - hw/register_file.sv
  - hw/execute_unit.sv
  - hw/shader_core.sv
  - target: simulation
    files:
      - tb/core_assert.sv
      - tb/core_tb.sv

// ==== files.f ====
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/rv_decoder.sv
hw/register_file.sv
hw/execute_unit.sv
hw/shader_core.sv
tb/core_assert.sv
tb/core_tb.sv

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    // Byte address into the data RAM
    localparam int DATA_ADDRESS_WIDTH = 16;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] pc;
        logic [WORD_WIDTH-1:0] inst;
    } queue_entry_t;

    // Taken branch or jump, valid for one cycle
    typedef struct packed {
        logic                  valid;
        logic [WORD_WIDTH-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [DATA_ADDRESS_WIDTH-1:0] address;
        logic [WORD_WIDTH-1:0]         write_data;
        logic                          write;
    } data_req_t;

endpackage

`default_nettype wire

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            run,
    input  logic                            pop_valid,
    input  core_pkg::queue_entry_t          pop_entry,
    output logic                            pop_ready,
    output core_pkg::redirect_t             redirect,
    output core_pkg::data_req_t             data_ram_req,
    input  logic [core_pkg::WORD_WIDTH-1:0] data_ram_read_result,
    output logic                            halted,
    output logic                            exception
);

    rv_isa_pkg::decoded_inst_t decoded;
    logic [core_pkg::WORD_WIDTH-1:0] rs1_data;
    logic [core_pkg::WORD_WIDTH-1:0] rs2_data;
    logic [core_pkg::WORD_WIDTH-1:0] op_a;
    logic [core_pkg::WORD_WIDTH-1:0] op_b;
    logic [core_pkg::WORD_WIDTH-1:0] alu_result;
    logic [core_pkg::WORD_WIDTH-1:0] rd_value;
    logic branch_taken;
    logic retire;
    // Second cycle of a load
    logic load_pending;
    logic [core_pkg::REG_ADDR_WIDTH-1:0] load_rd;
    logic [core_pkg::DATA_ADDRESS_WIDTH-1:0] load_address;
    logic rf_write;
    logic [core_pkg::REG_ADDR_WIDTH-1:0] rf_write_address;
    logic [core_pkg::WORD_WIDTH-1:0] rf_write_data;

    rv_decoder rv_decoder_inst (
        .inst    (pop_entry.inst),
        .decoded (decoded)
    );

    register_file register_file_inst (
        .clock         (clock),
        .read1_address (decoded.rs1),
        .read2_address (decoded.rs2),
        .read1_data    (rs1_data),
        .read2_data    (rs2_data),
        .write_address (rf_write_address),
        .write         (rf_write),
        .write_data    (rf_write_data)
    );

    assign pop_ready = !load_pending && !halted;
    assign retire = run && pop_valid && pop_ready;

    assign op_a = decoded.use_pc ? pop_entry.pc : rs1_data;
    assign op_b = decoded.use_imm ? decoded.imm : rs2_data;

    always_comb begin
        case (decoded.alu_op)
            rv_isa_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_isa_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_isa_pkg::ALU_SLL:  alu_result = op_a << op_b[4:0];
            rv_isa_pkg::ALU_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_SLTU: alu_result = {31'd0, op_a < op_b};
            rv_isa_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_isa_pkg::ALU_SRL:  alu_result = op_a >> op_b[4:0];
            rv_isa_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
            rv_isa_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_isa_pkg::ALU_AND:  alu_result = op_a & op_b;
            default:              alu_result = '0;
        endcase
    end

    always_comb begin
        case (decoded.branch_cond)
            rv_isa_pkg::F3_BEQ:  branch_taken = (rs1_data == rs2_data);
            rv_isa_pkg::F3_BNE:  branch_taken = (rs1_data != rs2_data);
            rv_isa_pkg::F3_BLT:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            rv_isa_pkg::F3_BGE:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_isa_pkg::F3_BLTU: branch_taken = rs1_data < rs2_data;
            rv_isa_pkg::F3_BGEU: branch_taken = rs1_data >= rs2_data;
            default:             branch_taken = 1'b0;
        endcase
    end

    // Bit 0 is cleared for jalr, already zero for jal and branches
    assign redirect.valid = retire &&
        (decoded.is_jal || decoded.is_jalr || (decoded.is_branch && branch_taken));
    assign redirect.target = {alu_result[core_pkg::WORD_WIDTH-1:1], 1'b0};

    // Link value for jumps
    assign rd_value = (decoded.is_jal || decoded.is_jalr) ? pop_entry.pc + 32'd4 : alu_result;

    // Load data arrives while pop_ready is low, so the ports never collide
    always_comb begin
        if (load_pending) begin
            rf_write = run;
            rf_write_address = load_rd;
            rf_write_data = data_ram_read_result;
        end else begin
            rf_write = retire && decoded.writes_rd && !decoded.is_load;
            rf_write_address = decoded.rd;
            rf_write_data = rd_value;
        end
    end

    // Load address is held so a stalled second cycle still sees the same word
    assign data_ram_req.address = load_pending ?
        load_address : alu_result[core_pkg::DATA_ADDRESS_WIDTH-1:0];
    assign data_ram_req.write_data = rs2_data;
    assign data_ram_req.write = retire && decoded.is_store;

    always_ff @(posedge clock) begin
        if (retire && decoded.is_load) begin
            load_rd <= decoded.writes_rd ? decoded.rd : '0;
            load_address <= alu_result[core_pkg::DATA_ADDRESS_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            load_pending <= 1'b0;
            halted <= 1'b0;
            exception <= 1'b0;
        end else if (run) begin
            load_pending <= retire && decoded.is_load;
            if (retire && (decoded.is_halt || decoded.is_illegal)) begin
                halted <= 1'b1;
                exception <= decoded.is_illegal;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int ADDRESS_WIDTH = 16
) (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            run,
    input  core_pkg::redirect_t             redirect,
    output logic [ADDRESS_WIDTH-1:0]        inst_ram_address,
    input  logic [core_pkg::WORD_WIDTH-1:0] inst_ram_read_result,
    output logic                            push_valid,
    input  logic                            push_ready,
    output core_pkg::queue_entry_t          push_entry
);

    // Address whose word sits on the RAM output this cycle
    logic [core_pkg::WORD_WIDTH-1:0] pc;
    logic [core_pkg::WORD_WIDTH-1:0] next_pc;
    // Low until the first read after reset has returned
    logic entry_valid;

    assign push_valid = entry_valid;
    assign push_entry.pc = pc;
    assign push_entry.inst = inst_ram_read_result;

    always_comb begin
        if (redirect.valid) begin
            // Stale read is dropped, target goes out right away
            next_pc = redirect.target;
        end else if (entry_valid && push_ready && run) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    // Holding the address keeps the same word on the RAM output under stall
    assign inst_ram_address = next_pc[ADDRESS_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pc <= '0;
            entry_valid <= 1'b0;
        end else if (run) begin
            pc <= next_pc;
            entry_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   run,
    input  logic                   flush,
    input  logic                   push_valid,
    input  core_pkg::queue_entry_t push_entry,
    output logic                   push_ready,
    output logic                   pop_valid,
    output core_pkg::queue_entry_t pop_entry,
    input  logic                   pop_ready
);

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    core_pkg::queue_entry_t entries [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] read_ptr;
    logic [PTR_WIDTH-1:0] write_ptr;
    logic [PTR_WIDTH:0]   count;
    logic do_push;
    logic do_pop;

    assign push_ready = (count != (PTR_WIDTH + 1)'(QUEUE_DEPTH));
    assign pop_valid = (count != '0);
    assign pop_entry = entries[read_ptr];

    assign do_push = run && push_valid && push_ready;
    assign do_pop = run && pop_valid && pop_ready;

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[write_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end else if (run && flush) begin
            // Everything queued is past a taken branch
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (do_pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
            count <= count + {{PTR_WIDTH{1'b0}}, do_push} - {{PTR_WIDTH{1'b0}}, do_pop};
        end
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                clock,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] read1_address,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] read2_address,
    output logic [core_pkg::WORD_WIDTH-1:0]     read1_data,
    output logic [core_pkg::WORD_WIDTH-1:0]     read2_data,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] write_address,
    input  logic                                write,
    input  logic [core_pkg::WORD_WIDTH-1:0]     write_data
);

    logic [core_pkg::WORD_WIDTH-1:0] registers [2**core_pkg::REG_ADDR_WIDTH];

    // x0 reads as zero whatever was written there
    assign read1_data = (read1_address == '0) ? '0 : registers[read1_address];
    assign read2_data = (read2_address == '0) ? '0 : registers[read2_address];

    always_ff @(posedge clock) begin
        if (write) begin
            registers[write_address] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic [31:0]               inst,
    output rv_isa_pkg::decoded_inst_t decoded
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::alu_op_t alu_sel;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic is_reg_reg;

    assign opcode = rv_isa_pkg::opcode_t'(inst[6:0]);
    assign is_reg_reg = (opcode == rv_isa_pkg::OPC_OP);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Bit 30 picks sub (register form only) and arithmetic shift
    always_comb begin
        case (inst[14:12])
            rv_isa_pkg::F3_ADD_SUB: begin
                alu_sel = (is_reg_reg && inst[30]) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::F3_SLL:  alu_sel = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  alu_sel = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: alu_sel = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  alu_sel = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: begin
                alu_sel = inst[30] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            end
            rv_isa_pkg::F3_OR:   alu_sel = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:  alu_sel = rv_isa_pkg::ALU_AND;
            default:             alu_sel = rv_isa_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        decoded = '0;
        decoded.rs1 = inst[19:15];
        decoded.rs2 = inst[24:20];
        decoded.rd = inst[11:7];
        decoded.branch_cond = inst[14:12];
        decoded.alu_op = rv_isa_pkg::ALU_ADD;
        decoded.imm = imm_i;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                decoded.alu_op = alu_sel;
                decoded.use_imm = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_OP: begin
                decoded.alu_op = alu_sel;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                // x0 as first operand gives 0 + imm
                decoded.rs1 = 5'd0;
                decoded.imm = imm_u;
                decoded.use_imm = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                decoded.imm = imm_u;
                decoded.use_imm = 1'b1;
                decoded.use_pc = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                decoded.imm = imm_j;
                decoded.use_imm = 1'b1;
                decoded.use_pc = 1'b1;
                decoded.is_jal = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                decoded.use_imm = 1'b1;
                decoded.is_jalr = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // ALU forms the target, rs1/rs2 go to the comparator
                decoded.imm = imm_b;
                decoded.use_imm = 1'b1;
                decoded.use_pc = 1'b1;
                decoded.is_branch = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD: begin
                decoded.use_imm = 1'b1;
                decoded.is_load = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                decoded.imm = imm_s;
                decoded.use_imm = 1'b1;
                decoded.is_store = 1'b1;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                // ebreak only, anything else is a no-op
                decoded.is_halt = (inst[31:20] == 12'd1);
            end
            default: begin
                decoded.is_illegal = 1'b1;
            end
        endcase
        if (decoded.rd == 5'd0) begin
            decoded.writes_rd = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_t     alu_op;
        logic [31:0] imm;
        logic        use_imm;
        logic        use_pc;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic        is_load;
        logic        is_store;
        logic        writes_rd;
        logic        is_halt;
        logic        is_illegal;
        logic [2:0]  branch_cond;
    } decoded_inst_t;

endpackage

`default_nettype wire

// ==== hw/shader_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module shader_core #(
    parameter int ADDRESS_WIDTH = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            run,
    output logic [ADDRESS_WIDTH-1:0]        inst_ram_address,
    input  logic [core_pkg::WORD_WIDTH-1:0] inst_ram_read_result,
    output core_pkg::data_req_t             data_ram_req,
    input  logic [core_pkg::WORD_WIDTH-1:0] data_ram_read_result,
    output logic                            halted,
    output logic                            exception
);

    logic push_valid;
    logic push_ready;
    logic pop_valid;
    logic pop_ready;
    core_pkg::queue_entry_t push_entry;
    core_pkg::queue_entry_t pop_entry;
    core_pkg::redirect_t redirect;

    fetch_unit #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) fetch_unit_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .redirect             (redirect),
        .inst_ram_address     (inst_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .push_valid           (push_valid),
        .push_ready           (push_ready),
        .push_entry           (push_entry)
    );

    // A redirect flushes whatever was fetched past the branch
    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) inst_queue_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .run        (run),
        .flush      (redirect.valid),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_entry  (pop_entry),
        .pop_ready  (pop_ready)
    );

    execute_unit execute_unit_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .pop_valid            (pop_valid),
        .pop_entry            (pop_entry),
        .pop_ready            (pop_ready),
        .redirect             (redirect),
        .data_ram_req         (data_ram_req),
        .data_ram_read_result (data_ram_read_result),
        .halted               (halted),
        .exception            (exception)
    );

endmodule

`default_nettype wire

// ==== tb/core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_assert (
    input logic                clock,
    input logic                reset_n,
    input logic                run,
    input core_pkg::data_req_t data_ram_req,
    input logic                halted,
    input logic                exception
);

    int failure_count = 0;

    // Exception always comes with a halt
    exception_implies_halted: assert property (
        @(posedge clock) disable iff (!reset_n) exception |-> halted
    ) else begin
        failure_count++;
        $error("exception high without halted");
    end

    halted_stays_high: assert property (
        @(posedge clock) disable iff (!reset_n) halted |=> halted
    ) else begin
        failure_count++;
        $error("halted fell outside reset");
    end

    no_write_when_stopped: assert property (
        @(posedge clock) disable iff (!reset_n)
            !(data_ram_req.write && (halted || !run))
    ) else begin
        failure_count++;
        $error("data RAM write while halted or stalled");
    end

endmodule

bind shader_core core_assert core_assert_inst (
    .clock        (clock),
    .reset_n      (reset_n),
    .run          (run),
    .data_ram_req (data_ram_req),
    .halted       (halted),
    .exception    (exception)
);

`default_nettype wire

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int CLOCK_PERIOD = 4;
    localparam int NUM_PROGRAMS = 12;
    localparam int PROG_LEN = 48;
    localparam int NUM_REGS_USED = 8;
    localparam int WATCHDOG_NS = NUM_PROGRAMS * PROG_LEN * 8 * CLOCK_PERIOD
        + NUM_PROGRAMS * 40 * CLOCK_PERIOD;
    localparam logic [31:0] EBREAK = 32'h00100073;
    // Opcode 1111111 is not RV32I
    localparam logic [31:0] ILLEGAL = 32'h0000007f;

    logic clock;
    logic reset_n;
    logic run;
    logic [15:0] inst_ram_address;
    logic [31:0] inst_ram_read_result = '0;
    core_pkg::data_req_t data_ram_req;
    logic [31:0] data_ram_read_result = '0;
    logic halted;
    logic exception;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] model_dmem [256];
    logic [31:0] model_regs [32];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] seed;
    int writes_seen;
    int model_writes;
    int error_count;
    logic stalling;
    logic expect_exception;

    shader_core #(
        .ADDRESS_WIDTH (16),
        .QUEUE_DEPTH   (4)
    ) shader_core_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .inst_ram_address     (inst_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_req         (data_ram_req),
        .data_ram_read_result (data_ram_read_result),
        .halted               (halted),
        .exception            (exception)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'd0, seed[30:15]};
    endfunction

    task automatic report_failure(input string why);
        error_count++;
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
        end
    endtask

    // Both RAMs read synchronously, one cycle after the address
    always @(posedge clock) begin
        inst_ram_read_result <= imem[inst_ram_address[7:2]];
        data_ram_read_result <= dmem[data_ram_req.address[9:2]];
        if (reset_n && data_ram_req.write) begin
            if (!run) begin
                report_failure("data RAM write issued while run is low");
            end
            if (exp_addr.size() == 0) begin
                report_failure("data RAM write beyond the expected stores");
            end
            check_value("data_ram_req.address", 32'(data_ram_req.address), exp_addr[0]);
            check_value("data_ram_req.write_data", data_ram_req.write_data, exp_data[0]);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            writes_seen++;
            dmem[data_ram_req.address[9:2]] <= data_ram_req.write_data;
        end
    end

    // Bound assertions on the core count their failures
    always @(negedge clock) begin
        if (shader_core_inst.core_assert_inst.failure_count != 0) begin
            report_failure("an assertion on the core failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("timeout: the core did not halt in time");
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Forward-only jumps, so the last slot is always reached
    task automatic build_program(input logic end_illegal);
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] word;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        logic [20:0] off;
        int skip;
        for (int i = 0; i < 64; i++) begin
            imem[i] = EBREAK;
        end
        for (int i = 0; i < 256; i++) begin
            hi = lcg_next();
            lo = lcg_next();
            dmem[i] = {hi[15:0], lo[15:0]} ^ {24'd0, i[7:0]};
            model_dmem[i] = dmem[i];
        end
        for (int i = 1; i < NUM_REGS_USED; i++) begin
            word = lcg_next();
            imem[i - 1] = {word[11:0], 5'd0, 3'd0, 5'(i), 7'h13};
        end
        for (int i = NUM_REGS_USED - 1; i < PROG_LEN - 1; i++) begin
            r = lcg_next();
            rd = 5'(lcg_next() % NUM_REGS_USED);
            rs1 = 5'(lcg_next() % NUM_REGS_USED);
            rs2 = 5'(lcg_next() % NUM_REGS_USED);
            f3 = 3'(lcg_next());
            imm = 12'(lcg_next());
            skip = 1 + lcg_next() % 3;
            if ((r % 10 >= 8) && (i + skip + 1 > PROG_LEN - 1)) begin
                r = 0;
            end
            if (r % 10 <= 2) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, (f3 == 3'd5) & imm[10], 5'd0, imm[4:0]};
                end
                imem[i] = {imm, rs1, f3, rd, 7'h13};
            end else if (r % 10 <= 4) begin
                imem[i] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) & imm[0], 5'd0, rs2, rs1, f3, rd,
                           7'h33};
            end else if (r % 10 == 5) begin
                word = lcg_next();
                imem[i] = {word[19:0], rd, imm[0] ? 7'h37 : 7'h17};
            end else if (r % 10 == 6) begin
                imem[i] = {2'd0, imm[7:0], 2'd0, 5'd0, 3'd2, rd, 7'h03};
            end else if (r % 10 == 7) begin
                imm = {2'd0, imm[7:0], 2'd0};
                imem[i] = {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
            end else if (r % 10 == 8) begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = 3'd0;
                end
                off = 21'((skip + 1) * 4);
                imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
            end else if (imm[0]) begin
                off = 21'((skip + 1) * 4);
                imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
            end else begin
                // Absolute target from x0, odd on purpose at times
                imm = 12'((i + skip + 1) * 4) | {11'd0, imm[1]};
                imem[i] = {imm, 5'd0, 3'd0, rd, 7'h67};
            end
        end
        imem[PROG_LEN - 1] = end_illegal ? ILLEGAL : EBREAK;
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        int steps;
        pc = 0;
        steps = 0;
        model_writes = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        forever begin
            inst = imem[pc[7:2]];
            a = model_regs[inst[19:15]];
            b = model_regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            result = '0;
            steps++;
            if (steps > 1000) begin
                report_failure("reference model did not reach the end of the program");
            end
            case (inst[6:0])
                7'h13: result = alu_ref(inst[14:12], 1'b0, a, imm_i) |
                    ((inst[14:12] == 3'd5 && inst[30]) ? alu_ref(3'd5, 1'b1, a, imm_i) : '0);
                7'h33: result = alu_ref(inst[14:12], inst[30], a, b);
                7'h37: result = {inst[31:12], 12'd0};
                7'h17: result = pc + {inst[31:12], 12'd0};
                7'h03: result = model_dmem[(a + imm_i) >> 2];
                7'h6f: result = pc + 4;
                7'h67: result = pc + 4;
                7'h23: begin
                    model_dmem[(a + imm_s) >> 2] = b;
                    exp_addr.push_back((a + imm_s) & 32'hffff);
                    exp_data.push_back(b);
                    model_writes++;
                end
                7'h63: ;
                default: return;
            endcase
            if (inst[6:0] != 7'h23 && inst[6:0] != 7'h63 && inst[11:7] != 5'd0) begin
                model_regs[inst[11:7]] = result;
            end
            if (inst[6:0] == 7'h6f) begin
                pc = pc + imm_j;
            end else if (inst[6:0] == 7'h67) begin
                pc = (a + imm_i) & ~32'd1;
            end else if (inst[6:0] == 7'h63 && branch_ref(inst[14:12], a, b)) begin
                pc = pc + imm_b;
            end else begin
                pc = pc + 4;
            end
        end
    endtask

    initial begin
        seed = 32'd64121;
        reset_n = 1'b0;
        run = 1'b1;
        stalling = 1'b0;
        error_count = 0;
        writes_seen = 0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            @(negedge clock);
            reset_n = 1'b0;
            run = 1'b1;
            expect_exception = (p % 3 == 2);
            exp_addr.delete();
            exp_data.delete();
            build_program(expect_exception);
            run_model();
            writes_seen = 0;
            repeat (8) @(negedge clock);
            reset_n = 1'b1;
            stalling = (p % 2 == 1);
            // Random stalls on every other program
            while (!halted) begin
                if (stalling) begin
                    run = (lcg_next() % 4) != 0;
                end
                @(negedge clock);
            end
            run = 1'b1;
            // No write and no change of state once halted
            repeat (10) begin
                @(negedge clock);
                check_value("halted", 32'(halted), 32'd1);
                check_value("exception", 32'(exception), 32'(expect_exception));
            end
            check_value("write count", 32'(writes_seen), 32'(model_writes));
        end
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
